//--- bench/rtn_xbar_tb.sv
`timescale 1ns/1ps

module rtn_xbar_tb
    import mpc_types::*;
();

    // the random mix needs a few hundred cycles and the other tests far fewer
    localparam int MAX_CYCLES = 4000;

    typedef struct packed {
        rob_id_t   rob_id;
        rsp_data_t data;
    } exp_rsp_t;

    logic                      clk;
    logic                      rst;
    bank_rsp_t [NUM_BANKS-1:0] bank_rsp;
    logic [NUM_BANKS-1:0]      bank_ready;
    ch_rsp_t [NUM_CH-1:0]      ch_rsp;

    // expected responses, one queue per bank and channel
    exp_rsp_t             exp_q [NUM_BANKS][NUM_CH][$];
    logic [31:0]          lfsr;
    logic [NUM_BANKS-1:0] acc_seen;
    int                   rob_cnt [NUM_BANKS];
    int                   to_send [NUM_BANKS];
    int                   fixed_ch [NUM_BANKS];
    logic                 use_gaps;
    int                   log_ch;
    int                   win_log [$];
    int                   strobes [NUM_CH];
    int                   accepted;
    int                   delivered;
    int                   cycles;
    string                cur_test;
    int                   test_errors;
    int                   total_errors;
    int                   tests_failed;
    int                   tests_run;

    rtn_xbar_top #(
        .ENTRIES    (8)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .bank_rsp   (bank_rsp),
        .bank_ready (bank_ready),
        .ch_rsp     (ch_rsp)
    );

    always #5 clk = ~clk;

    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [127:0] rand_bits(int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[126:0], rand_bit()};
        return v;
    endfunction

    function automatic bank_rsp_t make_rsp(int b, int ch);
        bank_rsp_t r;
        r.valid  = 1'b1;
        r.ch_id  = ch_id_t'(ch);
        // the low two bits name the bank, so ids never repeat across banks
        r.rob_id = rob_id_t'((rob_cnt[b] << 2) + b);
        r.data   = rand_bits(128);
        rob_cnt[b]++;
        return r;
    endfunction

    // an accepted response is expected later on its channel in bank order
    function automatic void expect_rsp(int b, bank_rsp_t r);
        exp_rsp_t e;
        e.rob_id = r.rob_id;
        e.data   = r.data;
        // channel 3 is reserved and never offered
        if (r.ch_id != 2'd3)
        begin
            exp_q[b][int'(r.ch_id)].push_back(e);
            accepted++;
        end
    endfunction

    function automatic int pending_total();
        int n;
        n = 0;
        for (int b = 0; b < NUM_BANKS; b++)
            for (int c = 0; c < NUM_CH; c++)
                n += exp_q[b][c].size();
        return n;
    endfunction

    task automatic report_mismatch(string what, logic [127:0] expected, logic [127:0] actual);
        $display("FAILED %s %s expected %0h actual %0h", cur_test, what, expected, actual);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_problem(string msg);
        $display("%s: %s", cur_test, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test(string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0)
            $display("test %s passed", cur_test);
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic do_reset();
        rst      = 1'b1;
        bank_rsp = '0;
        repeat (3)
            @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic set_traffic(int b, int n, int ch);
        to_send[b]  = n;
        fixed_ch[b] = ch;
    endtask

    // each bank holds its response until accepted, then offers the next one
    task automatic run_traffic();
        logic busy;
        int   ch;
        busy = 1'b1;
        while (busy)
        begin
            @(posedge clk);
            #1;
            busy = 1'b0;
            for (int b = 0; b < NUM_BANKS; b++)
            begin
                if (!bank_rsp[b].valid || acc_seen[b])
                begin
                    bank_rsp[b].valid = 1'b0;
                    if (to_send[b] > 0 && (!use_gaps || rand_bit()))
                    begin
                        ch = fixed_ch[b];
                        while (ch < 0 || ch == 3)
                            ch = int'(rand_bits(2));
                        bank_rsp[b] = make_rsp(b, ch);
                        to_send[b]--;
                    end
                end
                if (bank_rsp[b].valid || to_send[b] > 0)
                    busy = 1'b1;
            end
        end
        while (pending_total() > 0)
            @(posedge clk);
        repeat (3)
            @(posedge clk);
        #1;
    endtask

    // strobes are matched against the queue heads, then acceptances are recorded
    always @(negedge clk)
    begin
        logic     found;
        logic     have;
        exp_rsp_t head;
        acc_seen = '0;
        if (!rst)
        begin
            for (int c = 0; c < NUM_CH; c++)
            begin
                if (ch_rsp[c].valid)
                begin
                    found = 1'b0;
                    for (int b = 0; b < NUM_BANKS; b++)
                    begin
                        if (!found && exp_q[b][c].size() > 0
                            && exp_q[b][c][0].rob_id == ch_rsp[c].rob_id)
                        begin
                            found = 1'b1;
                            head  = exp_q[b][c][0];
                            if (head.data !== ch_rsp[c].data)
                                report_mismatch($sformatf("ch%0d data", c), head.data,
                                                ch_rsp[c].data);
                            void'(exp_q[b][c].pop_front());
                            if (c == log_ch)
                                win_log.push_back(b);
                        end
                    end
                    if (!found)
                    begin
                        have = 1'b0;
                        for (int b = NUM_BANKS - 1; b >= 0; b--)
                        begin
                            if (exp_q[b][c].size() > 0)
                            begin
                                have = 1'b1;
                                head = exp_q[b][c][0];
                            end
                        end
                        if (have)
                            report_mismatch($sformatf("ch%0d rob_id", c), head.rob_id,
                                            ch_rsp[c].rob_id);
                        else
                            report_problem($sformatf("channel %0d strobed with nothing pending",
                                                     c));
                    end
                    strobes[c]++;
                    delivered++;
                end
            end
            for (int b = 0; b < NUM_BANKS; b++)
            begin
                acc_seen[b] = bank_rsp[b].valid && bank_ready[b];
                if (acc_seen[b])
                    expect_rsp(b, bank_rsp[b]);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles in test %s with %0d responses undelivered",
                     cycles, cur_test, pending_total());
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        bank_rsp_t sent;
        int        s0;
        int        acc0;
        int        del0;
        int        acc;
        logic      took;
        clk          = 1'b0;
        rst          = 1'b1;
        bank_rsp     = '0;
        lfsr         = 32'h2a8c9e43;
        use_gaps     = 1'b0;
        log_ch       = -1;
        accepted     = 0;
        delivered    = 0;
        cycles       = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_failed = 0;
        tests_run    = 0;
        cur_test     = "reset";
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            rob_cnt[b] = 0;
            set_traffic(b, 0, 0);
        end
        for (int c = 0; c < NUM_CH; c++)
            strobes[c] = 0;
        do_reset();

        start_test("reset_state");
        @(negedge clk);
        if (bank_ready !== 4'hf)
            report_mismatch("bank_ready", 4'hf, bank_ready);
        for (int c = 0; c < NUM_CH; c++)
            if (ch_rsp[c].valid !== 1'b0)
                report_problem($sformatf("channel %0d valid is set after reset", c));
        end_test();

        start_test("single_response");
        @(posedge clk);
        #1;
        s0          = strobes[1];
        sent        = make_rsp(2, 1);
        bank_rsp[2] = sent;
        @(negedge clk);
        if (!bank_ready[2])
            report_problem("bank 2 did not accept the response");
        @(posedge clk);
        #1;
        bank_rsp[2].valid = 1'b0;
        @(negedge clk);
        if (!ch_rsp[1].valid)
            report_problem("channel 1 did not strobe in the cycle after acceptance");
        if (ch_rsp[1].rob_id !== sent.rob_id)
            report_mismatch("rob_id", sent.rob_id, ch_rsp[1].rob_id);
        if (ch_rsp[1].data !== sent.data)
            report_mismatch("data", sent.data, ch_rsp[1].data);
        repeat (4)
            @(posedge clk);
        if (strobes[1] - s0 != 1)
            report_mismatch("channel 1 strobe count", 1, strobes[1] - s0);
        end_test();

        // bank 1 competes for channel 0 so that bank 0 builds a backlog
        start_test("in_order_one_bank");
        s0 = strobes[0];
        set_traffic(0, 10, 0);
        set_traffic(1, 10, 0);
        run_traffic();
        if (strobes[0] - s0 != 20)
            report_mismatch("channel 0 strobe count", 20, strobes[0] - s0);
        end_test();

        start_test("alternating_banks");
        log_ch = 2;
        win_log.delete();
        set_traffic(1, 6, 2);
        set_traffic(2, 6, 2);
        run_traffic();
        log_ch = -1;
        if (win_log.size() != 12)
            report_mismatch("channel 2 strobe count", 12, win_log.size());
        for (int i = 1; i < win_log.size(); i++)
            if (win_log[i] != 3 - win_log[i-1])
                report_mismatch($sformatf("winning bank at strobe %0d", i),
                                3 - win_log[i-1], win_log[i]);
        end_test();

        start_test("random_mix");
        acc0     = accepted;
        del0     = delivered;
        use_gaps = 1'b1;
        for (int b = 0; b < NUM_BANKS; b++)
            set_traffic(b, 24, -1);
        run_traffic();
        use_gaps = 1'b0;
        if (delivered - del0 != accepted - acc0)
            report_mismatch("delivered count", accepted - acc0, delivered - del0);
        end_test();

        // reserved channel ids are never read, so bank 3 fills up
        start_test("full_bank");
        do_reset();
        acc = 0;
        @(posedge clk);
        #1;
        bank_rsp[3] = make_rsp(3, 3);
        repeat (12)
        begin
            @(negedge clk);
            took = bank_rsp[3].valid && bank_ready[3];
            if (took)
                acc++;
            @(posedge clk);
            #1;
            if (took)
                bank_rsp[3] = make_rsp(3, 3);
        end
        @(negedge clk);
        if (acc != 8)
            report_mismatch("accepted count", 8, acc);
        if (bank_ready[3] !== 1'b0)
            report_problem("bank 3 is still ready with every entry taken");
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- common/mpc_types.sv
package mpc_types;

    // bank and channel counts of the return path
    localparam int NUM_BANKS = 4;
    localparam int NUM_CH    = 3;

    // one response line as it leaves a data bank
    typedef logic [127:0]         rsp_data_t;

    // channel number carried with each response where value 3 is reserved
    typedef logic [1:0]           ch_id_t;

    // reorder buffer tag returned to the requester
    typedef logic [7:0]           rob_id_t;

    // one-hot select over the data banks
    typedef logic [NUM_BANKS-1:0] bank_sel_t;

    // one response offered by a data bank
    typedef struct packed {
        logic      valid;
        ch_id_t    ch_id;
        rob_id_t   rob_id;
        rsp_data_t data;
    } bank_rsp_t;

    // one response delivered to a channel whose valid is a single cycle strobe
    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        rsp_data_t data;
    } ch_rsp_t;

endpackage

//--- rtn_xbar/rtn_xbar_bank_ctrl.sv
`timescale 1ns/1ps

module rtn_xbar_bank_ctrl
    import mpc_types::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
)
(
    input  logic                           clk,
    input  logic                           rst,
    input  bank_rsp_t                      bank_rsp,
    output logic                           ready,
    output logic                           write_en,
    output logic [IDX_W-1:0]               w_entry_id,
    output logic [NUM_CH-1:0]              ch_cand,
    output logic [NUM_CH-1:0][ENTRIES-1:0] ch_r_entry_1hot_id,
    input  logic [NUM_CH-1:0]              ch_grant
);

    logic [ENTRIES-1:0]              free_q;
    ch_id_t                          ch_id_q [ENTRIES];
    // age_q[i][j] set means entry i was stored before entry j
    logic [ENTRIES-1:0][ENTRIES-1:0] age_q;
    logic [ENTRIES-1:0]              wr_1hot;
    logic [ENTRIES-1:0]              release_mask;
    logic [NUM_CH-1:0][ENTRIES-1:0]  ch_match;

    assign ready    = |free_q;
    assign write_en = bank_rsp.valid & ready;

    // lowest free entry takes the next response
    always_comb
    begin
        w_entry_id = '0;
        for (int i = ENTRIES - 1; i >= 0; i--)
        begin
            if (free_q[i])
            begin
                w_entry_id = IDX_W'(i);
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < ENTRIES; i++)
        begin
            wr_1hot[i] = write_en && (w_entry_id == IDX_W'(i));
        end
    end

    // reserved id 3 never matches a channel
    always_comb
    begin
        for (int c = 0; c < NUM_CH; c++)
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                ch_match[c][i] = !free_q[i] && (ch_id_q[i] == ch_id_t'(c));
            end
        end
    end

    // an entry is the candidate when no older entry waits for the same channel
    always_comb
    begin
        for (int c = 0; c < NUM_CH; c++)
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                ch_r_entry_1hot_id[c][i] = ch_match[c][i];
                for (int j = 0; j < ENTRIES; j++)
                begin
                    if (ch_match[c][j] && age_q[j][i])
                    begin
                        ch_r_entry_1hot_id[c][i] = 1'b0;
                    end
                end
            end
            ch_cand[c] = |ch_r_entry_1hot_id[c];
        end
    end

    always_comb
    begin
        release_mask = '0;
        for (int c = 0; c < NUM_CH; c++)
        begin
            if (ch_grant[c])
            begin
                release_mask = release_mask | ch_r_entry_1hot_id[c];
            end
        end
    end

    // a released entry is never the one written, since only free entries get written
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            free_q <= '1;
            age_q  <= '0;
        end
        else
        begin
            free_q <= (free_q | release_mask) & ~wr_1hot;
            if (write_en)
            begin
                // the new entry is younger than everything already stored
                for (int j = 0; j < ENTRIES; j++)
                begin
                    age_q[j][w_entry_id] <= 1'b1;
                    age_q[w_entry_id][j] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            ch_id_q[w_entry_id] <= bank_rsp.ch_id;
        end
    end

endmodule

//--- rtn_xbar/rtn_xbar_buffer.sv
`timescale 1ns/1ps

module rtn_xbar_buffer
    import mpc_types::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
)
(
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [NUM_BANKS-1:0]                          write_en,
    input  logic [NUM_BANKS-1:0][IDX_W-1:0]               w_entry_id,
    input  bank_rsp_t [NUM_BANKS-1:0]                     bank_rsp,
    input  logic [NUM_BANKS-1:0][NUM_CH-1:0][ENTRIES-1:0] r_entry_1hot_id,
    input  bank_sel_t [NUM_CH-1:0]                        ch_bank_sel,
    output rsp_data_t [NUM_CH-1:0]                        ch_rsp_data,
    output rob_id_t   [NUM_CH-1:0]                        ch_rsp_rob_id
);

    // read port outputs of every bank are indexed by bank then channel
    rsp_data_t [NUM_BANKS-1:0][NUM_CH-1:0] bank_ch_data;
    rob_id_t   [NUM_BANKS-1:0][NUM_CH-1:0] bank_ch_rob_id;

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        rtn_xbar_sub_buffer #(
            .ENTRIES            (ENTRIES)
        ) u_sub_buffer (
            .clk                (clk),
            .rst                (rst),
            .write_en           (write_en[b]),
            .w_entry_id         (w_entry_id[b]),
            .wr_data            (bank_rsp[b].data),
            .wr_rob_id          (bank_rsp[b].rob_id),
            .ch_r_entry_1hot_id (r_entry_1hot_id[b]),
            .ch_rsp_data        (bank_ch_data[b]),
            .ch_rsp_rob_id      (bank_ch_rob_id[b])
        );
    end

    // the bank select is one-hot, so an and-or mux is enough and gives zero when idle
    always_comb
    begin
        for (int c = 0; c < NUM_CH; c++)
        begin
            ch_rsp_data[c]   = '0;
            ch_rsp_rob_id[c] = '0;
            for (int b = 0; b < NUM_BANKS; b++)
            begin
                if (ch_bank_sel[c][b])
                begin
                    ch_rsp_data[c]   = ch_rsp_data[c] | bank_ch_data[b][c];
                    ch_rsp_rob_id[c] = ch_rsp_rob_id[c] | bank_ch_rob_id[b][c];
                end
            end
        end
    end

endmodule

//--- rtn_xbar/rtn_xbar_sub_buffer.sv
`timescale 1ns/1ps

module rtn_xbar_sub_buffer
    import mpc_types::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
)
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           write_en,
    input  logic [IDX_W-1:0]               w_entry_id,
    input  rsp_data_t                      wr_data,
    input  rob_id_t                        wr_rob_id,
    input  logic [NUM_CH-1:0][ENTRIES-1:0] ch_r_entry_1hot_id,
    output rsp_data_t [NUM_CH-1:0]         ch_rsp_data,
    output rob_id_t   [NUM_CH-1:0]         ch_rsp_rob_id
);

    rsp_data_t                    data_q   [ENTRIES];
    rob_id_t                      rob_id_q [ENTRIES];
    logic [NUM_CH-1:0][IDX_W-1:0] ch_r_entry_id;

    // the bank controller ignores acceptances during reset, so the storage does too
    always_ff @(posedge clk)
    begin
        if (write_en && !rst)
        begin
            data_q[w_entry_id]   <= wr_data;
            rob_id_q[w_entry_id] <= wr_rob_id;
        end
    end

    // one-hot entry select to binary index, per channel
    always_comb
    begin
        for (int c = 0; c < NUM_CH; c++)
        begin
            ch_r_entry_id[c] = '0;
            for (int i = 0; i < ENTRIES; i++)
            begin
                if (ch_r_entry_1hot_id[c][i])
                begin
                    ch_r_entry_id[c] = ch_r_entry_id[c] | IDX_W'(i);
                end
            end
        end
    end

    for (genvar c = 0; c < NUM_CH; c++)
    begin : g_rd_port
        assign ch_rsp_data[c]   = data_q[ch_r_entry_id[c]];
        assign ch_rsp_rob_id[c] = rob_id_q[ch_r_entry_id[c]];
    end

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module rtn_xbar_tb -Mdir obj_dir -f vlog.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vrtn_xbar_tb) || { printf '%s\n' "$out"; echo "simulation failed"; exit 1; }
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'No errors' && exit 0 || exit 1

//--- src/rtn_ch_arbiter.sv
`timescale 1ns/1ps

module rtn_ch_arbiter
    import mpc_types::*;
(
    input  logic      clk,
    input  logic      rst,
    input  bank_sel_t cand,
    output bank_sel_t grant
);

    localparam int PTR_W = $clog2(NUM_BANKS);

    // bank with the highest priority in the current cycle
    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] win_idx;
    logic             found;

    always_comb
    begin
        int idx;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int k = 0; k < NUM_BANKS; k++)
        begin
            idx = (int'(ptr_q) + k) % NUM_BANKS;
            if (!found && cand[idx])
            begin
                found   = 1'b1;
                win_idx = PTR_W'(idx);
            end
        end
        grant[win_idx] = found;
    end

    // step past the winner so the other banks come first next time
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ptr_q <= '0;
        end
        else if (found)
        begin
            if (win_idx == PTR_W'(NUM_BANKS - 1))
            begin
                ptr_q <= '0;
            end
            else
            begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

endmodule

//--- src/rtn_xbar_top.sv
`timescale 1ns/1ps

module rtn_xbar_top
    import mpc_types::*;
#(
    parameter int  ENTRIES = 8,
    localparam int IDX_W   = $clog2(ENTRIES)
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  bank_rsp_t [NUM_BANKS-1:0] bank_rsp,
    output logic [NUM_BANKS-1:0]  bank_ready,
    output ch_rsp_t [NUM_CH-1:0]  ch_rsp
);

    logic [NUM_BANKS-1:0]                          bank_write_en;
    logic [NUM_BANKS-1:0][IDX_W-1:0]               bank_w_entry_id;
    logic [NUM_BANKS-1:0][NUM_CH-1:0]              bank_ch_cand;
    logic [NUM_BANKS-1:0][NUM_CH-1:0]              bank_ch_grant;
    logic [NUM_BANKS-1:0][NUM_CH-1:0][ENTRIES-1:0] bank_r_entry_1hot_id;
    bank_sel_t [NUM_CH-1:0]                        ch_cand;
    bank_sel_t [NUM_CH-1:0]                        ch_grant;
    rsp_data_t [NUM_CH-1:0]                        ch_rsp_data;
    rob_id_t   [NUM_CH-1:0]                        ch_rsp_rob_id;

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        rtn_xbar_bank_ctrl #(
            .ENTRIES            (ENTRIES)
        ) u_bank_ctrl (
            .clk                (clk),
            .rst                (rst),
            .bank_rsp           (bank_rsp[b]),
            .ready              (bank_ready[b]),
            .write_en           (bank_write_en[b]),
            .w_entry_id         (bank_w_entry_id[b]),
            .ch_cand            (bank_ch_cand[b]),
            .ch_r_entry_1hot_id (bank_r_entry_1hot_id[b]),
            .ch_grant           (bank_ch_grant[b])
        );

        // candidates are gathered per channel, grants scattered back per bank
        for (genvar c = 0; c < NUM_CH; c++)
        begin : g_xpose
            assign ch_cand[c][b]       = bank_ch_cand[b][c];
            assign bank_ch_grant[b][c] = ch_grant[c][b];
        end
    end

    for (genvar c = 0; c < NUM_CH; c++)
    begin : g_ch
        rtn_ch_arbiter u_arbiter (
            .clk   (clk),
            .rst   (rst),
            .cand  (ch_cand[c]),
            .grant (ch_grant[c])
        );

        assign ch_rsp[c].valid  = |ch_grant[c];
        assign ch_rsp[c].rob_id = ch_rsp_rob_id[c];
        assign ch_rsp[c].data   = ch_rsp_data[c];
    end

    rtn_xbar_buffer #(
        .ENTRIES         (ENTRIES)
    ) u_buffer (
        .clk             (clk),
        .rst             (rst),
        .write_en        (bank_write_en),
        .w_entry_id      (bank_w_entry_id),
        .bank_rsp        (bank_rsp),
        .r_entry_1hot_id (bank_r_entry_1hot_id),
        .ch_bank_sel     (ch_grant),
        .ch_rsp_data     (ch_rsp_data),
        .ch_rsp_rob_id   (ch_rsp_rob_id)
    );

endmodule

//--- vlog.f
common/mpc_types.sv
src/rtn_ch_arbiter.sv
rtn_xbar/rtn_xbar_sub_buffer.sv
rtn_xbar/rtn_xbar_buffer.sv
rtn_xbar/rtn_xbar_bank_ctrl.sv
src/rtn_xbar_top.sv
bench/rtn_xbar_tb.sv
